// File: Bender.yml
package:
  name: sigdecode_h

sources:
  - sigdecode_h_pkg.sv
  - sigdecode_h_ctrl_if.sv
  - sigdecode_h_ctrl.sv
  - sigdecode_h_hintsum.sv
  - sigdecode_h_bitmap.sv
  - sigdecode_h_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - sigdecode_h_tb.sv

// File: all.f
sigdecode_h_pkg.sv
sigdecode_h_ctrl_if.sv
sigdecode_h_ctrl.sv
sigdecode_h_hintsum.sv
sigdecode_h_bitmap.sv
sigdecode_h_top.sv
tb_clk_gen.sv
sigdecode_h_tb.sv

// File: sigdecode_h_bitmap.sv
// Hint bitmap builder
`timescale 1ns/1ps

module sigdecode_h_bitmap #(
    parameter int MLDSA_N = 256
) (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                zeroize,
    input  logic [31:0]         hint_rd_data,
    output logic [3:0]          wr_data,
    output logic                order_error,
    sigdecode_h_ctrl_if.bitmap  ctrl_if
);

    logic [MLDSA_N-1:0] bitmap;
    logic [MLDSA_N-1:0] set_mask;
    logic               hint_rd_en_f;
    logic [7:0]         last_idx;
    logic               last_valid;
    logic [7:0]         scan_idx;
    logic               scan_valid;
    logic               order_bad;

    // Index word arrives one cycle after its strobe
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            hint_rd_en_f <= 1'b0;
        end else if (zeroize) begin
            hint_rd_en_f <= 1'b0;
        end else begin
            hint_rd_en_f <= ctrl_if.hint_rd_en;
        end
    end

    // --------------------------------------------------
    // Decode the masked bytes of the fetched word
    // --------------------------------------------------
    always_comb begin
        set_mask   = '0;
        scan_idx   = last_idx;
        scan_valid = last_valid;
        order_bad  = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (ctrl_if.curr_poly_map[i]) begin
                // Each index must lie above the one before, also across words
                if (scan_valid && (hint_rd_data[8*i +: 8] <= scan_idx)) begin
                    order_bad = 1'b1;
                end
                set_mask[hint_rd_data[8*i +: 8]] = 1'b1;
                scan_idx   = hint_rd_data[8*i +: 8];
                scan_valid = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            bitmap      <= '0;
            last_idx    <= 8'd0;
            last_valid  <= 1'b0;
            order_error <= 1'b0;
        end else if (zeroize || ctrl_if.rst_bitmap) begin
            bitmap      <= '0;
            last_idx    <= 8'd0;
            last_valid  <= 1'b0;
            order_error <= 1'b0;
        end else if (hint_rd_en_f) begin
            bitmap      <= bitmap | set_mask;
            last_idx    <= scan_idx;
            last_valid  <= scan_valid;
            order_error <= order_error | order_bad;
        end
    end

    // Four coefficients per memory word, lowest coefficient in bit 0
    always_comb begin
        wr_data = bitmap[ctrl_if.bitmap_ptr +: 4];
    end

    // Every fetched word carries a contiguous low run of valid bytes, and none otherwise
    assert property (@(posedge clk) disable iff (!reset_n)
        (hint_rd_en_f == (ctrl_if.curr_poly_map != 4'b0000)) &&
        (ctrl_if.curr_poly_map inside {4'b0000, 4'b0001, 4'b0011, 4'b0111, 4'b1111}));

endmodule

// File: sigdecode_h_ctrl.sv
// Hint decoder read and write control
`timescale 1ns/1ps

module sigdecode_h_ctrl #(
    parameter int MLDSA_N     = 256,
    parameter int MLDSA_K     = 8,
    parameter int MLDSA_OMEGA = 80
) (
    input  logic                                       clk,
    input  logic                                       reset_n,
    input  logic                                       zeroize,
    input  logic                                       enable,
    input  logic [sigdecode_h_pkg::mem_addr_width-1:0] dest_base_addr,
    input  logic [7:0]                                 hintsum,
    input  logic                                       sum_error,
    input  logic                                       order_error,
    output logic                                       mem_wr_en,
    output logic [sigdecode_h_pkg::mem_addr_width-1:0] mem_wr_addr,
    output logic [3:0]                                 poly_count,
    output logic                                       latch_hintsum,
    output logic                                       done,
    output logic                                       error,
    sigdecode_h_ctrl_if.ctrl                           ctrl_if
);
    import sigdecode_h_pkg::*;

    localparam int PTR_W = $clog2(MLDSA_N);

    sdh_read_state_e  rd_state;
    sdh_read_state_e  rd_state_nxt;
    sdh_write_state_e wr_state;
    sdh_write_state_e wr_state_nxt;
    mem_rw_mode_e     rd_wr_en;

    logic       sigdecode_h_error;
    logic       err_any;
    logic       start;
    logic       last_poly;
    logic       poly_done_rd;
    logic       poly_done_wr;
    logic       hint_rd_en_f;
    logic       wr_go;
    logic       incr_poly;
    logic [7:0] rem_hintsum;
    logic [3:0] tail_map;

    // --------------------------------------------------
    // Status flags
    // --------------------------------------------------
    always_comb begin
        sigdecode_h_error = sum_error | order_error;
        // Raw flags stop the FSMs at once, the sticky copy keeps them stopped
        err_any      = sigdecode_h_error | error;
        done         = (rd_state == SDH_RD_IDLE) && (wr_state == SDH_WR_IDLE);
        start        = done && enable;
        last_poly    = (poly_count == 4'(MLDSA_K - 1));
        poly_done_rd = (rd_state == SDH_RD_EXEC) && (rem_hintsum == 8'd0);
        poly_done_wr = (ctrl_if.bitmap_ptr == PTR_W'(MLDSA_N - 4));
    end

    // Valid byte mask for the last, partly used word of a polynomial
    always_comb begin
        case (rem_hintsum)
            8'd1:    tail_map = 4'b0001;
            8'd2:    tail_map = 4'b0011;
            8'd3:    tail_map = 4'b0111;
            default: tail_map = 4'b1111;
        endcase
    end

    // --------------------------------------------------
    // Read FSM
    // --------------------------------------------------
    always_comb begin
        rd_state_nxt       = rd_state;
        latch_hintsum      = 1'b0;
        ctrl_if.hint_rd_en = 1'b0;

        case (rd_state)
            SDH_RD_IDLE: begin
                if (start) begin
                    rd_state_nxt = SDH_RD_INIT;
                end
            end
            SDH_RD_INIT: begin
                // Wait until the previous polynomial has been written out
                if (err_any) begin
                    rd_state_nxt = SDH_RD_IDLE;
                end else if (wr_state == SDH_WR_INIT) begin
                    rd_state_nxt = SDH_RD_HINTSUM;
                end
            end
            SDH_RD_HINTSUM: begin
                latch_hintsum = 1'b1;
                rd_state_nxt  = SDH_RD_EXEC;
            end
            default: begin
                if (err_any || (poly_done_rd && last_poly)) begin
                    rd_state_nxt = SDH_RD_IDLE;
                end else if (poly_done_rd) begin
                    rd_state_nxt = SDH_RD_INIT;
                end else begin
                    ctrl_if.hint_rd_en = 1'b1;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_state     <= SDH_RD_IDLE;
            wr_state     <= SDH_WR_IDLE;
            hint_rd_en_f <= 1'b0;
        end else if (zeroize) begin
            rd_state     <= SDH_RD_IDLE;
            wr_state     <= SDH_WR_IDLE;
            hint_rd_en_f <= 1'b0;
        end else begin
            rd_state     <= rd_state_nxt;
            wr_state     <= wr_state_nxt;
            hint_rd_en_f <= ctrl_if.hint_rd_en;
        end
    end

    // Remaining hints of the current polynomial, four consumed per fetch
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rem_hintsum           <= 8'd0;
            ctrl_if.curr_poly_map <= 4'b0000;
        end else if (zeroize) begin
            rem_hintsum           <= 8'd0;
            ctrl_if.curr_poly_map <= 4'b0000;
        end else if (latch_hintsum) begin
            rem_hintsum           <= hintsum;
            ctrl_if.curr_poly_map <= 4'b0000;
        end else if (ctrl_if.hint_rd_en) begin
            rem_hintsum           <= (rem_hintsum > 8'd4) ? rem_hintsum - 8'd4 : 8'd0;
            ctrl_if.curr_poly_map <= tail_map;
        end else begin
            ctrl_if.curr_poly_map <= 4'b0000;
        end
    end

    // Byte pointer into the index area
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ctrl_if.rd_ptr <= 7'd0;
        end else if (zeroize || start) begin
            ctrl_if.rd_ptr <= 7'd0;
        end else if (ctrl_if.hint_rd_en) begin
            if (rem_hintsum >= 8'd4) begin
                ctrl_if.rd_ptr <= ctrl_if.rd_ptr + 7'd4;
            end else begin
                ctrl_if.rd_ptr <= ctrl_if.rd_ptr + rem_hintsum[6:0];
            end
        end
    end

    // --------------------------------------------------
    // Write FSM
    // --------------------------------------------------
    always_comb begin
        wr_state_nxt = wr_state;
        wr_go        = 1'b0;

        case (wr_state)
            SDH_WR_IDLE: begin
                if (start) begin
                    wr_state_nxt = SDH_WR_INIT;
                end
            end
            SDH_WR_INIT: begin
                // Start once the first index word has landed, or at once for no hints
                if (err_any) begin
                    wr_state_nxt = SDH_WR_IDLE;
                end else if (hint_rd_en_f || poly_done_rd) begin
                    wr_state_nxt = SDH_WR_MEM;
                end
            end
            default: begin
                wr_go = !err_any;
                if (err_any || (poly_done_wr && last_poly)) begin
                    wr_state_nxt = SDH_WR_IDLE;
                end else if (poly_done_wr) begin
                    wr_state_nxt = SDH_WR_INIT;
                end
            end
        endcase
    end

    always_comb begin
        rd_wr_en           = wr_go ? RW_WRITE : RW_IDLE;
        mem_wr_en          = (rd_wr_en == RW_WRITE);
        incr_poly          = wr_go && poly_done_wr;
        // Clear at run start and after the last nibble of each polynomial
        ctrl_if.rst_bitmap = start || incr_poly;
    end

    // Write address, nibble pointer and polynomial counter
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mem_wr_addr        <= '0;
            ctrl_if.bitmap_ptr <= '0;
            poly_count         <= 4'd0;
        end else if (zeroize) begin
            mem_wr_addr        <= '0;
            ctrl_if.bitmap_ptr <= '0;
            poly_count         <= 4'd0;
        end else if (start) begin
            mem_wr_addr        <= dest_base_addr;
            ctrl_if.bitmap_ptr <= '0;
            poly_count         <= 4'd0;
        end else if (wr_go) begin
            mem_wr_addr        <= mem_wr_addr + 1'b1;
            ctrl_if.bitmap_ptr <= poly_done_wr ? '0 : ctrl_if.bitmap_ptr + PTR_W'(4);
            if (incr_poly) begin
                poly_count <= poly_count + 4'd1;
            end
        end
    end

    // Sticky error, cleared by the next run
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            error <= 1'b0;
        end else if (zeroize || start) begin
            error <= 1'b0;
        end else if (sigdecode_h_error) begin
            error <= 1'b1;
        end
    end

    // --------------------------------------------------
    // Assertions
    // --------------------------------------------------
    // Writes come only from WR_MEM and never overlap the count latch of the next polynomial
    assert property (@(posedge clk) disable iff (!reset_n)
        mem_wr_en |-> (wr_state == SDH_WR_MEM) && !latch_hintsum &&
            (poly_count < 4'(MLDSA_K)));

    // Accumulated fetch advances stay inside the index area
    assert property (@(posedge clk) disable iff (!reset_n)
        ctrl_if.rd_ptr <= 7'(MLDSA_OMEGA));

endmodule

// File: sigdecode_h_ctrl_if.sv
// Controller to bitmap builder link
`timescale 1ns/1ps

interface sigdecode_h_ctrl_if #(
    parameter int MLDSA_N = 256
) ();

    // Index word fetch strobe and byte pointer
    logic                       hint_rd_en;
    logic [6:0]                 rd_ptr;

    // Bytes of the fetched word that belong to the current polynomial
    logic [3:0]                 curr_poly_map;

    // Coefficient position of the nibble being written out
    logic [$clog2(MLDSA_N)-1:0] bitmap_ptr;
    logic                       rst_bitmap;

    modport ctrl (
        output hint_rd_en,
        output rd_ptr,
        output curr_poly_map,
        output bitmap_ptr,
        output rst_bitmap
    );

    modport bitmap (
        input hint_rd_en,
        input curr_poly_map,
        input bitmap_ptr,
        input rst_bitmap
    );

endinterface

// File: sigdecode_h_hintsum.sv
// Per-polynomial hint count
`timescale 1ns/1ps

module sigdecode_h_hintsum #(
    parameter int MLDSA_OMEGA = 80
) (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       zeroize,
    input  logic       enable,
    input  logic       latch_hintsum,
    input  logic [7:0] hint_sum_cum,
    output logic [7:0] hintsum,
    output logic       sum_error
);

    logic [7:0] prev_cum;
    logic       count_bad;

    // Count of this polynomial is the step in the running total
    always_comb begin
        hintsum   = hint_sum_cum - prev_cum;
        count_bad = (hint_sum_cum < prev_cum) || (hint_sum_cum > 8'(MLDSA_OMEGA));
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prev_cum  <= 8'd0;
            sum_error <= 1'b0;
        end else if (zeroize || enable) begin
            prev_cum  <= 8'd0;
            sum_error <= 1'b0;
        end else if (latch_hintsum) begin
            if (count_bad) begin
                sum_error <= 1'b1;
            end else begin
                prev_cum <= hint_sum_cum;
            end
        end
    end

    // A latched count larger than the index area is always flagged
    assert property (@(posedge clk) disable iff (!reset_n)
        latch_hintsum && !zeroize && !enable && (hintsum > 8'(MLDSA_OMEGA)) |=>
            sum_error);

endmodule

// File: sigdecode_h_pkg.sv
// Hint decoder shared definitions

package sigdecode_h_pkg;

    // Destination memory address width
    localparam int mem_addr_width = 10;

    // Destination memory operation
    typedef enum logic [1:0] {
        RW_IDLE  = 2'd0,
        RW_READ  = 2'd1,
        RW_WRITE = 2'd2
    } mem_rw_mode_e;

    // Read FSM walks the index bytes of the hint field
    typedef enum logic [1:0] {
        SDH_RD_IDLE    = 2'd0,
        SDH_RD_INIT    = 2'd1,
        SDH_RD_HINTSUM = 2'd2,
        SDH_RD_EXEC    = 2'd3
    } sdh_read_state_e;

    // Write FSM streams each bitmap out to memory
    typedef enum logic [1:0] {
        SDH_WR_IDLE = 2'd0,
        SDH_WR_INIT = 2'd1,
        SDH_WR_MEM  = 2'd2
    } sdh_write_state_e;

endpackage

// File: sigdecode_h_tb.sv
// Hint decoder testbench
`timescale 1ns/1ps

module sigdecode_h_tb;
    import sigdecode_h_pkg::*;

    localparam int N     = 256;
    localparam int K     = 4;
    localparam int OMEGA = 80;
    localparam int WORDS = N / 4;
    // Seven decodes of roughly 300 cycles each, plus margin
    localparam int TIMEOUT_CYCLES = 3000;

    logic                      clk;
    logic                      reset_n;
    logic                      zeroize;
    logic                      enable;
    logic [mem_addr_width-1:0] dest_base_addr;
    logic [31:0]               hint_rd_data;
    logic [7:0]                hint_sum_cum;
    logic                      hint_rd_en;
    logic [6:0]                hint_rd_addr;
    logic [3:0]                hint_sum_idx;
    logic                      mem_wr_en;
    logic [mem_addr_width-1:0] mem_wr_addr;
    logic [3:0]                mem_wr_data;
    logic                      done;
    logic                      error;

    logic [7:0]   hint_buf [OMEGA + K];
    logic [N-1:0] exp_map  [K];
    logic [3:0]   cap_mem  [1 << mem_addr_width];
    int           cap_hits [1 << mem_addr_width];
    int           cap_count;
    int           cap_gaps;
    int           cap_last;
    int           cap_max;
    int           check_count = 0;
    int           error_count = 0;
    int           cycle_count = 0;
    logic [31:0]  lcg_state   = 32'd47293;

    tb_clk_gen i_clk_gen (
        .clk     (clk),
        .reset_n (reset_n)
    );

    sigdecode_h_top #(
        .MLDSA_N     (N),
        .MLDSA_K     (K),
        .MLDSA_OMEGA (OMEGA)
    ) i_sigdecode_h_top (
        .clk            (clk),
        .reset_n        (reset_n),
        .zeroize        (zeroize),
        .enable         (enable),
        .dest_base_addr (dest_base_addr),
        .hint_rd_data   (hint_rd_data),
        .hint_sum_cum   (hint_sum_cum),
        .hint_rd_en     (hint_rd_en),
        .hint_rd_addr   (hint_rd_addr),
        .hint_sum_idx   (hint_sum_idx),
        .mem_wr_en      (mem_wr_en),
        .mem_wr_addr    (mem_wr_addr),
        .mem_wr_data    (mem_wr_data),
        .done           (done),
        .error          (error)
    );

    // --------------------------------------------------
    // Memory models
    // --------------------------------------------------
    function automatic logic [31:0] fetch_word(input int addr);
        logic [31:0] word;
        word = '0;
        for (int b = 0; b < 4; b++) begin
            if (addr + b < OMEGA + K) begin
                word[8*b +: 8] = hint_buf[addr + b];
            end
        end
        return word;
    endfunction

    // Hint buffer answers one cycle after the strobe
    always @(posedge clk) begin
        if (hint_rd_en) begin
            check_value("hint_rd_addr below OMEGA", hint_rd_addr < OMEGA, 1'b1);
            hint_rd_data <= fetch_word(int'(hint_rd_addr));
        end
    end

    assign hint_sum_cum = (hint_sum_idx < K) ? hint_buf[OMEGA + hint_sum_idx] : 8'd0;

    always @(negedge clk) begin
        if (mem_wr_en) begin
            if (cap_count > 0 && int'(mem_wr_addr) != cap_last + 1) begin
                cap_gaps++;
            end
            cap_mem[mem_wr_addr] = mem_wr_data;
            cap_hits[mem_wr_addr]++;
            cap_count++;
            cap_last = int'(mem_wr_addr);
            cap_max  = (cap_last > cap_max) ? cap_last : cap_max;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the decoder did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    function automatic int next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[30:16]);
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL at %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
        end
    endtask

    task automatic clear_maps();
        for (int p = 0; p < K; p++) begin
            exp_map[p] = '0;
        end
    endtask

    // Index area holds the set bits in ascending order, then the running totals
    task automatic load_hints();
        int ptr;
        ptr = 0;
        for (int i = 0; i < OMEGA + K; i++) begin
            hint_buf[i] = 8'd0;
        end
        for (int p = 0; p < K; p++) begin
            for (int c = 0; c < N; c++) begin
                if (exp_map[p][c]) begin
                    hint_buf[ptr] = 8'(c);
                    ptr++;
                end
            end
            hint_buf[OMEGA + p] = 8'(ptr);
        end
    endtask

    task automatic clear_capture();
        for (int a = 0; a < (1 << mem_addr_width); a++) begin
            cap_mem[a]  = 4'h0;
            cap_hits[a] = 0;
        end
        cap_count = 0;
        cap_gaps  = 0;
        cap_last  = -1;
        cap_max   = -1;
    endtask

    task automatic start_decode(input int base);
        dest_base_addr = mem_addr_width'(base);
        enable = 1'b1;
        @(negedge clk);
        enable = 1'b0;
        check_value("done", done, 1'b0);
        check_value("hint_rd_addr", hint_rd_addr, 7'd0);
        check_value("hint_sum_idx", hint_sum_idx, 4'd0);
    endtask

    task automatic wait_done();
        while (!done) begin
            @(negedge clk);
        end
    endtask

    task automatic check_memory(input int base);
        int addr;
        check_value("error", error, 1'b0);
        check_value("write count", cap_count, K * WORDS);
        check_value("address gaps", cap_gaps, 0);
        for (int p = 0; p < K; p++) begin
            for (int w = 0; w < WORDS; w++) begin
                addr = base + p * WORDS + w;
                check_value($sformatf("writes to %0d", addr), cap_hits[addr], 1);
                check_value($sformatf("mem_wr_data at %0d", addr), cap_mem[addr],
                            exp_map[p][4*w +: 4]);
            end
        end
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic empty_decode();
        clear_maps();
        load_hints();
        clear_capture();
        start_decode(0);
        wait_done();
        check_memory(0);
    endtask

    // Counts 3, 0, 5 and 1 leave partly used words
    task automatic mixed_count_decode();
        clear_maps();
        exp_map[0][0]   = 1'b1;
        exp_map[0][17]  = 1'b1;
        exp_map[0][255] = 1'b1;
        for (int c = 4; c < 8; c++) begin
            exp_map[2][c] = 1'b1;
        end
        exp_map[2][200] = 1'b1;
        exp_map[3][128] = 1'b1;
        load_hints();
        clear_capture();
        start_decode(64);
        wait_done();
        check_memory(64);
    endtask

    task automatic random_decode();
        int n;
        int base;
        clear_maps();
        for (int p = 0; p < K; p++) begin
            // At most 20 per polynomial keeps the total within the index area
            n = next_rand() % 21;
            repeat (n) begin
                exp_map[p][next_rand() % N] = 1'b1;
            end
        end
        base = 1 + next_rand() % 768;
        load_hints();
        clear_capture();
        start_decode(base);
        wait_done();
        check_memory(base);
    endtask

    // Running total drops at polynomial 2
    task automatic sum_decrease_abort();
        clear_maps();
        exp_map[0][10] = 1'b1;
        exp_map[0][20] = 1'b1;
        exp_map[1][30] = 1'b1;
        exp_map[2][40] = 1'b1;
        load_hints();
        hint_buf[OMEGA + 2] = 8'd1;
        clear_capture();
        start_decode(100);
        wait_done();
        check_value("error", error, 1'b1);
        check_value("last write below poly 2 end", cap_max < 100 + 3 * WORDS, 1'b1);
    endtask

    // Polynomial 1 holds 40, 20, 60
    task automatic order_error_abort();
        clear_maps();
        exp_map[0][3]  = 1'b1;
        exp_map[0][7]  = 1'b1;
        exp_map[1][20] = 1'b1;
        exp_map[1][40] = 1'b1;
        exp_map[1][60] = 1'b1;
        exp_map[2][80] = 1'b1;
        exp_map[3][90] = 1'b1;
        load_hints();
        hint_buf[2] = 8'd40;
        hint_buf[3] = 8'd20;
        clear_capture();
        start_decode(0);
        wait_done();
        check_value("error", error, 1'b1);
        check_value("run stopped early", cap_count < K * WORDS, 1'b1);
        check_value("last write below poly 1 end", cap_max < 2 * WORDS, 1'b1);
    endtask

    // Stop during the writes of polynomial 1
    task automatic zeroize_restart();
        clear_maps();
        exp_map[0][2]   = 1'b1;
        exp_map[0][9]   = 1'b1;
        exp_map[0][33]  = 1'b1;
        exp_map[0][34]  = 1'b1;
        exp_map[0][35]  = 1'b1;
        exp_map[0][100] = 1'b1;
        exp_map[2][255] = 1'b1;
        load_hints();
        clear_capture();
        start_decode(200);
        while (cap_count < WORDS + 36) begin
            @(negedge clk);
        end
        zeroize = 1'b1;
        @(negedge clk);
        zeroize = 1'b0;
        check_value("done", done, 1'b1);
        check_value("error", error, 1'b0);
        check_value("mem_wr_en", mem_wr_en, 1'b0);
        check_value("hint_rd_addr", hint_rd_addr, 7'd0);
        check_value("hint_sum_idx", hint_sum_idx, 4'd0);
        clear_capture();
        start_decode(200);
        wait_done();
        check_memory(200);
    endtask

    initial begin
        zeroize        = 1'b0;
        enable         = 1'b0;
        dest_base_addr = '0;
        hint_rd_data   = '0;
        for (int i = 0; i < OMEGA + K; i++) begin
            hint_buf[i] = 8'd0;
        end
        @(posedge reset_n);
        @(negedge clk);
        check_value("done", done, 1'b1);
        check_value("error", error, 1'b0);
        check_value("mem_wr_en", mem_wr_en, 1'b0);
        check_value("hint_rd_en", hint_rd_en, 1'b0);
        empty_decode();
        mixed_count_decode();
        random_decode();
        sum_decrease_abort();
        order_error_abort();
        zeroize_restart();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: sigdecode_h_top.sv
// Hint unpacking top level
`timescale 1ns/1ps

module sigdecode_h_top #(
    parameter int MLDSA_N     = 256,
    parameter int MLDSA_K     = 4,
    parameter int MLDSA_OMEGA = 80
) (
    input  logic                                       clk,
    input  logic                                       reset_n,
    input  logic                                       zeroize,
    input  logic                                       enable,
    input  logic [sigdecode_h_pkg::mem_addr_width-1:0] dest_base_addr,
    input  logic [31:0]                                hint_rd_data,
    input  logic [7:0]                                 hint_sum_cum,
    output logic                                       hint_rd_en,
    output logic [6:0]                                 hint_rd_addr,
    output logic [3:0]                                 hint_sum_idx,
    output logic                                       mem_wr_en,
    output logic [sigdecode_h_pkg::mem_addr_width-1:0] mem_wr_addr,
    output logic [3:0]                                 mem_wr_data,
    output logic                                       done,
    output logic                                       error
);

    logic [7:0] hintsum;
    logic       latch_hintsum;
    logic       sum_error;
    logic       order_error;

    sigdecode_h_ctrl_if #(.MLDSA_N(MLDSA_N)) ctrl_if ();

    sigdecode_h_ctrl #(
        .MLDSA_N     (MLDSA_N),
        .MLDSA_K     (MLDSA_K),
        .MLDSA_OMEGA (MLDSA_OMEGA)
    ) i_ctrl (
        .clk            (clk),
        .reset_n        (reset_n),
        .zeroize        (zeroize),
        .enable         (enable),
        .dest_base_addr (dest_base_addr),
        .hintsum        (hintsum),
        .sum_error      (sum_error),
        .order_error    (order_error),
        .mem_wr_en      (mem_wr_en),
        .mem_wr_addr    (mem_wr_addr),
        .poly_count     (hint_sum_idx),
        .latch_hintsum  (latch_hintsum),
        .done           (done),
        .error          (error),
        .ctrl_if        (ctrl_if.ctrl)
    );

    sigdecode_h_hintsum #(
        .MLDSA_OMEGA (MLDSA_OMEGA)
    ) i_hintsum (
        .clk           (clk),
        .reset_n       (reset_n),
        .zeroize       (zeroize),
        .enable        (enable),
        .latch_hintsum (latch_hintsum),
        .hint_sum_cum  (hint_sum_cum),
        .hintsum       (hintsum),
        .sum_error     (sum_error)
    );

    sigdecode_h_bitmap #(
        .MLDSA_N (MLDSA_N)
    ) i_bitmap (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize      (zeroize),
        .hint_rd_data (hint_rd_data),
        .wr_data      (mem_wr_data),
        .order_error  (order_error),
        .ctrl_if      (ctrl_if.bitmap)
    );

    // Hint buffer read port
    assign hint_rd_en   = ctrl_if.hint_rd_en;
    assign hint_rd_addr = ctrl_if.rd_ptr;

endmodule

// File: tb_clk_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD_NS    = 4.0,
    parameter int  RESET_CYCLES = 4
) (
    output logic clk,
    output logic reset_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // Release away from the rising edge
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
    end

endmodule
